// ==== source/stall_cfg_pkg.sv ====
`default_nettype none

package stall_cfg_pkg;

   // Word addresses of the Wishbone register map
   localparam logic [1:0] addr_ctrl  = 2'd0;
   localparam logic [1:0] addr_mask  = 2'd1;
   // Write only, reads back as zero
   localparam logic [1:0] addr_seed  = 2'd2;
   // Read gives the egress beat count and any write clears it
   localparam logic [1:0] addr_count = 2'd3;

   // Width of the random source and of each stall mask
   localparam int lfsr_width = 16;
   localparam int mask_width = 4;

   // Galois toggle mask for the polynomial x^16 + x^15 + x^13 + x^4 + 1
   localparam logic [lfsr_width-1:0] lfsr_taps = 16'hd008;

   // The egress gate scrambles the shared seed with this so the two gates do not stall in step
   localparam logic [lfsr_width-1:0] egress_seed_xor = 16'h5a3c;

   // Classic Wishbone request as driven by the master
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [1:0]  adr;
      logic [31:0] dat_w;
   } wb_req_t;

   // Slave response with read data valid together with ack
   typedef struct packed {
      logic        ack;
      logic [31:0] dat_r;
   } wb_rsp_t;

   // Settings of one stall gate
   typedef struct packed {
      logic                  enable;
      logic [mask_width-1:0] mask;
   } stall_cfg_t;

endpackage

`default_nettype wire

// ==== source/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

   // Payload width of one stream beat
   localparam int data_width = 32;

   // Number of beats the FIFO between the two gates can hold
   localparam int fifo_depth = 4;

   // Pointer and occupancy widths derived from the depth
   // The count needs one extra state to tell full from empty
   localparam int fifo_ptr_width   = $clog2(fifo_depth);
   localparam int fifo_count_width = $clog2(fifo_depth + 1);

   // One beat on the stream
   // Last marks the end of a packet and travels with the data unchanged
   typedef struct packed {
      logic [data_width-1:0] data;
      logic                  last;
   } stream_beat_t;

endpackage

`default_nettype wire

// ==== source/stall_lfsr.sv ====
`default_nettype none

module stall_lfsr (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 load,
   input  logic [stall_cfg_pkg::lfsr_width-1:0] seed,
   input  logic                                 step,
   output logic [stall_cfg_pkg::lfsr_width-1:0] value
);

   import stall_cfg_pkg::*;

   // The all zero state would lock the register so a zero seed becomes one
   logic [lfsr_width-1:0] seed_safe;

   assign seed_safe = (seed == '0) ? lfsr_width'(1) : seed;

   // Right shifting Galois form
   // When the bit shifted out is set the tap mask is folded into the new state
   // A load has priority over a step in the same cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         value <= lfsr_width'(1);
      end else if (load) begin
         value <= seed_safe;
      end else if (step) begin
         if (value[0]) begin
            value <= (value >> 1) ^ lfsr_taps;
         end else begin
            value <= value >> 1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/handshake_stall.sv ====
`default_nettype none

module handshake_stall #(
   // Set on the egress instance so it scrambles the shared seed
   parameter bit apply_seed_xor = 1'b0
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  stall_cfg_pkg::stall_cfg_t            cfg,
   input  logic                                 seed_load,
   input  logic [stall_cfg_pkg::lfsr_width-1:0] seed,

   // Upstream side faces the source of the beats
   input  logic                                 s_valid,
   output logic                                 s_ready,
   input  stream_pkg::stream_beat_t             s_beat,

   // Downstream side faces the sink of the beats
   output logic                                 m_valid,
   input  logic                                 m_ready,
   output stream_pkg::stream_beat_t             m_beat
);

   import stall_cfg_pkg::*;

   logic [mask_width-1:0] stall_count;
   logic [lfsr_width-1:0] lfsr_seed;
   logic [lfsr_width-1:0] lfsr_value;
   logic                  gate_open;
   logic                  stall_on;
   logic                  xfer;

   // Each instance starts its random sequence from its own seed
   assign lfsr_seed = apply_seed_xor ? (seed ^ egress_seed_xor) : seed;

   // A zero mask would only ever load zero so it counts as disabled
   assign stall_on = cfg.enable && (cfg.mask != '0);

   // The gate is transparent while no stall is counting down
   assign gate_open = (stall_count == '0);

   // Both directions close together so no transfer can happen during a gap
   assign s_ready = gate_open && m_ready;
   assign m_valid = gate_open && s_valid;
   assign m_beat  = s_beat;

   assign xfer = m_valid && m_ready;

   // After a transfer the gate closes for the masked random value
   // A result of zero leaves the gate open for the next beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         stall_count <= '0;
      end else if (!gate_open) begin
         stall_count <= stall_count - 1'b1;
      end else if (xfer && stall_on) begin
         stall_count <= lfsr_value[mask_width-1:0] & cfg.mask;
      end
   end

   // The random source advances once for every stall it decides
   stall_lfsr lfsr_i (
      .clk   (clk),
      .rst   (rst),
      .load  (seed_load),
      .seed  (lfsr_seed),
      .step  (xfer && stall_on),
      .value (lfsr_value)
   );

endmodule

`default_nettype wire

// ==== source/stream_fifo.sv ====
`default_nettype none

module stream_fifo (
   input  logic                     clk,
   input  logic                     rst,

   // Write side
   input  logic                     s_valid,
   output logic                     s_ready,
   input  stream_pkg::stream_beat_t s_beat,

   // Read side
   output logic                     m_valid,
   input  logic                     m_ready,
   output stream_pkg::stream_beat_t m_beat
);

   import stream_pkg::*;

   stream_beat_t                mem [fifo_depth];
   logic [fifo_ptr_width-1:0]   wr_ptr;
   logic [fifo_ptr_width-1:0]   rd_ptr;
   logic [fifo_count_width-1:0] count;
   logic                        full;
   logic                        wr_en;
   logic                        rd_en;

   assign full = (count == fifo_count_width'(fifo_depth));

   // When full a read in the same cycle frees the slot being written
   assign s_ready = !full || m_ready;

   // The head entry comes straight from the storage flops
   // A beat written into an empty buffer shows up one cycle later
   assign m_valid = (count != '0);
   assign m_beat  = mem[rd_ptr];

   assign wr_en = s_valid && s_ready;
   assign rd_en = m_valid && m_ready;

   // Each accepted beat lands in the slot at the write pointer
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= s_beat;
      end
   end

   // Pointers wrap at the depth and the count tracks occupancy
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves the count unchanged
         if (wr_en && !rd_en) begin
            count <= count + 1'b1;
         end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/stall_regs.sv ====
`default_nettype none

module stall_regs (
   input  logic                                 clk,
   input  logic                                 rst,
   input  stall_cfg_pkg::wb_req_t               wb_req,
   output stall_cfg_pkg::wb_rsp_t               wb_rsp,
   output stall_cfg_pkg::stall_cfg_t            ingress_cfg,
   output stall_cfg_pkg::stall_cfg_t            egress_cfg,
   output logic                                 seed_load,
   output logic [stall_cfg_pkg::lfsr_width-1:0] seed_value,

   // Egress handshake observed for the beat counter
   input  logic                                 m_valid,
   input  logic                                 m_ready
);

   import stall_cfg_pkg::*;

   logic        access;
   logic        wr_access;
   logic [31:0] rd_data;
   logic [31:0] beat_count;

   // A request is served once and ack blocks the next cycle
   // A master that keeps the strobe up gets a second response after a gap
   assign access    = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
   assign wr_access = access && wb_req.we;

   // Read mux gives the register contents at the time of the request
   always_comb begin
      case (wb_req.adr)
         addr_ctrl:  rd_data = {30'd0, egress_cfg.enable, ingress_cfg.enable};
         addr_mask:  rd_data = {24'd0, egress_cfg.mask, ingress_cfg.mask};
         addr_count: rd_data = beat_count;
         default:    rd_data = 32'd0;
      endcase
   end

   // Ack and read data leave from flops one cycle after the request
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_rsp.ack   <= 1'b0;
         wb_rsp.dat_r <= 32'd0;
      end else begin
         wb_rsp.ack <= access;
         if (access) begin
            wb_rsp.dat_r <= rd_data;
         end
      end
   end

   // Control and mask fields for both gates
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ingress_cfg <= '0;
         egress_cfg  <= '0;
      end else if (wr_access) begin
         if (wb_req.adr == addr_ctrl) begin
            ingress_cfg.enable <= wb_req.dat_w[0];
            egress_cfg.enable  <= wb_req.dat_w[1];
         end
         if (wb_req.adr == addr_mask) begin
            ingress_cfg.mask <= wb_req.dat_w[mask_width-1:0];
            egress_cfg.mask  <= wb_req.dat_w[2*mask_width-1:mask_width];
         end
      end
   end

   // Seed load is a single cycle strobe that comes with the ack
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         seed_load <= 1'b0;
      end else begin
         seed_load <= wr_access && (wb_req.adr == addr_seed);
      end
   end

   // Seed captured in the same cycle as the load strobe is raised
   always_ff @(posedge clk) begin
      if (wr_access && (wb_req.adr == addr_seed)) begin
         seed_value <= wb_req.dat_w[lfsr_width-1:0];
      end
   end

   // Egress beat counter
   // A clear wins over a beat leaving in the same cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_count <= 32'd0;
      end else if (wr_access && (wb_req.adr == addr_count)) begin
         beat_count <= 32'd0;
      end else if (m_valid && m_ready) begin
         beat_count <= beat_count + 32'd1;
      end
   end

endmodule

`default_nettype wire

// ==== source/stream_stall_top.sv ====
`default_nettype none

module stream_stall_top (
   input  logic                     clk,
   input  logic                     rst,

   // Register access
   input  stall_cfg_pkg::wb_req_t   wb_req,
   output stall_cfg_pkg::wb_rsp_t   wb_rsp,

   // Ingress stream port
   input  logic                     s_valid,
   output logic                     s_ready,
   input  stream_pkg::stream_beat_t s_beat,

   // Egress stream port
   output logic                     m_valid,
   input  logic                     m_ready,
   output stream_pkg::stream_beat_t m_beat
);

   import stall_cfg_pkg::*;
   import stream_pkg::*;

   stall_cfg_t            ingress_cfg;
   stall_cfg_t            egress_cfg;
   logic                  seed_load;
   logic [lfsr_width-1:0] seed_value;

   // Link from the ingress gate into the FIFO
   logic                  fifo_in_valid;
   logic                  fifo_in_ready;
   stream_beat_t          fifo_in_beat;

   // Link from the FIFO into the egress gate
   logic                  fifo_out_valid;
   logic                  fifo_out_ready;
   stream_beat_t          fifo_out_beat;

   stall_regs regs_i (
      .clk         (clk),
      .rst         (rst),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .ingress_cfg (ingress_cfg),
      .egress_cfg  (egress_cfg),
      .seed_load   (seed_load),
      .seed_value  (seed_value),
      .m_valid     (m_valid),
      .m_ready     (m_ready)
   );

   // Starves the FIFO by pausing the source side
   handshake_stall #(
      .apply_seed_xor (1'b0)
   ) ingress_stall (
      .clk       (clk),
      .rst       (rst),
      .cfg       (ingress_cfg),
      .seed_load (seed_load),
      .seed      (seed_value),
      .s_valid   (s_valid),
      .s_ready   (s_ready),
      .s_beat    (s_beat),
      .m_valid   (fifo_in_valid),
      .m_ready   (fifo_in_ready),
      .m_beat    (fifo_in_beat)
   );

   stream_fifo fifo_i (
      .clk     (clk),
      .rst     (rst),
      .s_valid (fifo_in_valid),
      .s_ready (fifo_in_ready),
      .s_beat  (fifo_in_beat),
      .m_valid (fifo_out_valid),
      .m_ready (fifo_out_ready),
      .m_beat  (fifo_out_beat)
   );

   // Fills the FIFO by pausing the sink side
   handshake_stall #(
      .apply_seed_xor (1'b1)
   ) egress_stall (
      .clk       (clk),
      .rst       (rst),
      .cfg       (egress_cfg),
      .seed_load (seed_load),
      .seed      (seed_value),
      .s_valid   (fifo_out_valid),
      .s_ready   (fifo_out_ready),
      .s_beat    (fifo_out_beat),
      .m_valid   (m_valid),
      .m_ready   (m_ready),
      .m_beat    (m_beat)
   );

endmodule

`default_nettype wire

// ==== testbench/stream_stall_assert.sv ====
`default_nettype none

module stream_stall_assert (
   input logic                     clk,
   input logic                     rst,
   input logic                     s_valid,
   input logic                     s_ready,
   input stream_pkg::stream_beat_t s_beat,
   input logic                     m_valid,
   input logic                     m_ready,
   input stream_pkg::stream_beat_t m_beat,
   input stall_cfg_pkg::wb_rsp_t   wb_rsp
);

   timeunit 1ns;
   timeprecision 100ps;

   // Number of assertion failures, read by the testbench at the end of the run
   int fail_count = 0;

   // A waiting source keeps valid up at the ingress port
   ingress_valid_hold: assert property (@(posedge clk) disable iff (rst)
      s_valid && !s_ready |=> s_valid)
      else begin
         $error("ingress valid dropped before its transfer");
         fail_count++;
      end

   // The DUT must behave the same way as a source at egress
   egress_valid_hold: assert property (@(posedge clk) disable iff (rst)
      m_valid && !m_ready |=> m_valid)
      else begin
         $error("egress valid dropped before its transfer");
         fail_count++;
      end

   ingress_beat_stable: assert property (@(posedge clk) disable iff (rst)
      s_valid && !s_ready |=> $stable(s_beat))
      else begin
         $error("ingress beat changed while waiting");
         fail_count++;
      end

   // FIFO head must not move while the sink holds it off
   egress_beat_stable: assert property (@(posedge clk) disable iff (rst)
      m_valid && !m_ready |=> $stable(m_beat))
      else begin
         $error("egress beat changed while waiting");
         fail_count++;
      end

   // Classic Wishbone ack is a single cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         $error("Wishbone ack held for more than one cycle");
         fail_count++;
      end

endmodule

`default_nettype wire

// ==== testbench/stream_stall_checker.sv ====
`default_nettype none

module stream_stall_checker (
   input logic                     clk,
   input logic                     rst,
   input logic                     s_valid,
   input logic                     s_ready,
   input stream_pkg::stream_beat_t s_beat,
   input logic                     m_valid,
   input logic                     m_ready,
   input stream_pkg::stream_beat_t m_beat
);

   timeunit 1ns;
   timeprecision 100ps;

   import stream_pkg::*;

   // Beats accepted at ingress and not yet seen at egress
   // Its size equals the FIFO occupancy since the ingress gate is combinational
   stream_beat_t pending_q [$];
   stream_beat_t expected;

   string test_name;
   int    error_count = 0;
   int    error_total = 0;
   int    check_count = 0;
   int    test_count = 0;
   int    failed_tests = 0;
   int    out_count = 0;
   int    gap_limit = 0;
   int    gap_run = 0;
   int    gap_hits = 0;
   bit    latency_mode = 1'b0;
   bit    expect_gap = 1'b0;
   bit    expect_full = 1'b0;
   bit    full_seen = 1'b0;
   bit    accepted_prev = 1'b0;

   task automatic report_failure(input string what);
      $display("Failure at %0t ns: %s", $time, what);
      error_count++;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("Error at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
         error_count++;
      end
   endtask

   // Egress mask bounds the gap only when the egress gate is enabled
   task automatic begin_test(input string name, input int ctrl, input int mask,
                             input bit lat, input bit gap, input bit full);
      test_name     = name;
      gap_limit     = ctrl[1] ? ((mask >> 4) & 15) : 0;
      latency_mode  = lat;
      expect_gap    = gap;
      expect_full   = full;
      full_seen     = 1'b0;
      gap_run       = 0;
      gap_hits      = 0;
      out_count     = 0;
      accepted_prev = 1'b0;
      error_count   = 0;
   endtask

   task automatic end_test();
      if (pending_q.size() != 0) report_failure("beats accepted at ingress never left");
      if (expect_gap && gap_hits == 0) report_failure("no egress stall gap seen with mask 15");
      if (expect_full && !full_seen) report_failure("FIFO never filled under back-pressure");
      $display("Test %-14s beats %0d gaps %0d errors %0d: %s", test_name, out_count,
               gap_hits, error_count, (error_count == 0) ? "ok" : "FAILED");
      test_count++;
      if (error_count != 0) failed_tests++;
      error_total += error_count;
   endtask

   task automatic print_totals();
      $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_total);
   endtask

   // Sampling at the falling edge sees the values that the next rising edge uses
   always @(negedge clk) begin
      if (rst) begin
         gap_run = 0;
         accepted_prev = 1'b0;
      end else begin
         // The FIFO holds beats, so a low m_valid means the egress gate is closed
         if (pending_q.size() > 0 && !m_valid) begin
            gap_run++;
            if (gap_run == 1) gap_hits++;
            if (gap_run == gap_limit + 1) begin
               report_failure($sformatf("egress gap longer than mask %0d", gap_limit));
            end
         end else begin
            gap_run = 0;
         end

         // Without stalls a beat shows at egress one cycle after ingress
         if (latency_mode && accepted_prev && !m_valid) begin
            report_failure("beat accepted last cycle is missing at m_valid");
         end
         if (latency_mode && s_valid && !s_ready) begin
            report_failure("continuous stream was held off at ingress");
         end

         if (pending_q.size() == fifo_depth) full_seen = 1'b1;
         if (pending_q.size() == fifo_depth && !m_ready && s_ready) begin
            report_failure("s_ready high with a full FIFO and m_ready low");
         end

         if (m_valid && m_ready) begin
            if (pending_q.size() == 0) begin
               report_failure("egress beat with nothing accepted at ingress");
            end else begin
               expected = pending_q.pop_front();
               check_value("m_beat.data", m_beat.data, expected.data);
               check_value("m_beat.last", {31'd0, m_beat.last}, {31'd0, expected.last});
               out_count++;
            end
         end

         accepted_prev = s_valid && s_ready;
         if (accepted_prev) begin
            pending_q.push_back(s_beat);
            if (pending_q.size() > fifo_depth) report_failure("more beats in flight than FIFO depth");
         end
      end
   end

endmodule

`default_nettype wire

// ==== testbench/stream_stall_tb.sv ====
`default_nettype none

module stream_stall_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import stall_cfg_pkg::*;
   import stream_pkg::*;

   localparam int num_tests = 6;

   // One row of the stimulus table
   // Mask holds the ingress nibble in 3:0 and the egress nibble in 7:4
   typedef struct packed {
      int ctrl;
      int mask;
      int beats;
      int duty;
      int seed;
      int hold;
   } test_row_t;

   test_row_t rows [num_tests] = '{
      '{ctrl: 0, mask: 'h00, beats: 24, duty: 100, seed: 'h1234, hold: 0},
      '{ctrl: 0, mask: 'h00, beats: 40, duty: 60,  seed: 'hbeef, hold: 0},
      '{ctrl: 1, mask: 'h07, beats: 40, duty: 80,  seed: 'h0001, hold: 0},
      '{ctrl: 2, mask: 'hf0, beats: 40, duty: 100, seed: 'hace1, hold: 0},
      '{ctrl: 3, mask: 'h3c, beats: 48, duty: 70,  seed: 'h0000, hold: 0},
      '{ctrl: 0, mask: 'h00, beats: 12, duty: 50,  seed: 'h7777, hold: 20}
   };

   string names [num_tests] = '{
      "pass_through", "random_ready", "ingress_stall",
      "egress_stall", "both_stall", "back_pressure"
   };

   logic         clk = 1'b0;
   logic         rst;
   wb_req_t      wb_req;
   wb_rsp_t      wb_rsp;
   logic         s_valid;
   logic         s_ready;
   stream_beat_t s_beat;
   logic         m_valid;
   logic         m_ready;
   stream_beat_t m_beat;
   logic [31:0]  beat_seq = 32'h0000_0100;

   stream_stall_top stream_stall_top_i (
      .clk     (clk),
      .rst     (rst),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .s_valid (s_valid),
      .s_ready (s_ready),
      .s_beat  (s_beat),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_beat  (m_beat)
   );

   stream_stall_checker scoreboard_i (
      .clk     (clk),
      .rst     (rst),
      .s_valid (s_valid),
      .s_ready (s_ready),
      .s_beat  (s_beat),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_beat  (m_beat)
   );

   bind stream_stall_top stream_stall_assert handshake_check_i (
      .clk     (clk),
      .rst     (rst),
      .s_valid (s_valid),
      .s_ready (s_ready),
      .s_beat  (s_beat),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_beat  (m_beat),
      .wb_rsp  (wb_rsp)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // Worst case per beat is the widest mask plus one cycle, four times over
   function automatic int watchdog_cycles();
      int total;
      int widest;
      total = 2000;
      for (int i = 0; i < num_tests; i++) begin
         widest = rows[i].mask & 15;
         if (((rows[i].mask >> 4) & 15) > widest) widest = (rows[i].mask >> 4) & 15;
         total += rows[i].beats * (widest + 1) * 4 + rows[i].hold;
      end
      return total;
   endfunction

   // Holds the request until ack was seen at a rising edge
   task automatic wait_ack();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         #1;
         waited++;
      end while (!wb_rsp.ack && waited < 16);
      if (!wb_rsp.ack) scoreboard_i.report_failure("Wishbone request got no ack");
      @(posedge clk);
      #1;
      wb_req = '0;
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = 1'b1;
      wb_req.adr   = adr;
      wb_req.dat_w = data;
      wait_ack();
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = 1'b0;
      wb_req.adr   = adr;
      wb_req.dat_w = 32'd0;
      wait_ack();
      data = wb_rsp.dat_r;
   endtask

   // Each beat stays on the port until a falling edge shows s_ready high
   task automatic send_beats(input int beats);
      logic taken;
      for (int i = 0; i < beats; i++) begin
         s_valid     = 1'b1;
         s_beat.data = beat_seq;
         s_beat.last = (i == beats - 1);
         beat_seq    = beat_seq + 32'd1;
         do begin
            @(negedge clk);
            taken = s_ready;
            @(posedge clk);
            #1;
         end while (!taken);
      end
      s_valid = 1'b0;
      s_beat  = '0;
   endtask

   // Sink side runs until every beat has left the DUT
   task automatic drive_ready(input int duty, input int hold, input int beats);
      int cycle;
      cycle = 0;
      while (scoreboard_i.out_count < beats) begin
         @(posedge clk);
         #1;
         if (cycle < hold) m_ready = 1'b0;
         else m_ready = (($urandom % 100) < duty);
         cycle++;
      end
      m_ready = 1'b1;
   endtask

   task automatic run_row(input int idx);
      test_row_t   row;
      logic [31:0] rd;
      row = rows[idx];
      scoreboard_i.begin_test(names[idx], row.ctrl, row.mask,
                              row.ctrl == 0 && row.duty == 100 && row.hold == 0,
                              row.ctrl[1] && ((row.mask >> 4) & 15) == 15,
                              row.hold > 0);
      wb_write(addr_seed, row.seed);
      wb_write(addr_mask, row.mask);
      wb_write(addr_ctrl, row.ctrl);
      wb_write(addr_count, 32'd0);
      wb_read(addr_ctrl, rd);
      scoreboard_i.check_value("ctrl", rd, row.ctrl);
      wb_read(addr_mask, rd);
      scoreboard_i.check_value("mask", rd, row.mask);
      wb_read(addr_seed, rd);
      scoreboard_i.check_value("seed readback", rd, 32'd0);
      wb_read(addr_count, rd);
      scoreboard_i.check_value("count after clear", rd, 32'd0);
      fork
         send_beats(row.beats);
         drive_ready(row.duty, row.hold, row.beats);
      join
      wb_read(addr_count, rd);
      scoreboard_i.check_value("count", rd, row.beats);
      scoreboard_i.end_test();
   endtask

   initial begin
      int limit;
      limit = watchdog_cycles();
      repeat (limit) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'h0d545ad3));
      rst     = 1'b1;
      wb_req  = '0;
      s_valid = 1'b0;
      s_beat  = '0;
      m_ready = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < num_tests; i++) begin
         run_row(i);
      end
      scoreboard_i.print_totals();
      if (scoreboard_i.error_total == 0 &&
          stream_stall_top_i.handshake_check_i.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== stream_stall.f ====
source/stall_cfg_pkg.sv
source/stream_pkg.sv
source/stall_lfsr.sv
source/handshake_stall.sv
source/stream_fifo.sv
source/stall_regs.sv
source/stream_stall_top.sv
testbench/stream_stall_assert.sv
testbench/stream_stall_checker.sv
testbench/stream_stall_tb.sv

// ==== Makefile ====
# Verilator build and run of the stream stall injector testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= stream_stall_tb
FILELIST  ?= stream_stall.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The status comes from the search for the pass text in the output
run: compile
	@./$(EXE) $(RUN_ARGS) | awk '{ print } index($$0, "$(PASS_TEXT)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
